//--- rtl/wbuf_settings.svh
// Build-time sizes of the weight buffer and its quantization side buffers
`ifndef WBUF_SETTINGS_SVH
`define WBUF_SETTINGS_SVH

// Bits in one incoming W row
`define WBUF_DW 128

// Buffer rows, one per PE row
`define WBUF_HEIGHT 4

// Pipeline registers inside each PE
`define WBUF_PIPE_REGS 1

// Quantization group index bits
`define WBUF_GID_W 4

// FP16 only
`define WBUF_ELEM_W 16

`define WBUF_D (`WBUF_DW / `WBUF_ELEM_W)              // Elements per row
`define WBUF_C (`WBUF_D / (`WBUF_PIPE_REGS + 1))      // Columns per row

`endif

//--- rtl/wbuf_pkg.sv
// Vector types shared by the weight buffer blocks
`include "wbuf_settings.svh"

package wbuf_pkg;

  // Half-precision weight element
  typedef logic [`WBUF_ELEM_W-1:0] elem_t;

  // Quantized weight or zero point
  typedef logic [7:0] qbyte_t;

  // Cache key, stride bit on top of the group index
  typedef logic [`WBUF_GID_W:0] gid_tag_t;

  // Selects one of the H rows or cache slots
  typedef logic [$clog2(`WBUF_HEIGHT)-1:0] slot_t;

  // Programmed width or height, must reach D inclusive
  typedef logic [$clog2(`WBUF_D):0] dcnt_t;

endpackage

//--- rtl/wbuf_ctrl_if.sv
// Control strobes and programming values from the top level to the buffer core
`timescale 1ns/1ps

interface wbuf_ctrl_if;
  import wbuf_pkg::*;

  logic  load;        // Write one row
  logic  shift;       // Read one element per row
  logic  dequant;     // Load carries a quantization group
  dcnt_t width;       // Valid elements per row
  dcnt_t height;      // Valid rows
  logic  stride_cnt;  // Upper bit of the cache key

  modport drv (
    output load,
    output shift,
    output dequant,
    output width,
    output height,
    output stride_cnt
  );

  modport core (
    input load,
    input shift,
    input dequant,
    input width,
    input height,
    input stride_cnt
  );

endinterface

//--- rtl/wbuf_scm.sv
// Register array storage with whole-row writes and a registered element read per row
`timescale 1ns/1ps

module wbuf_scm #(
  parameter  int unsigned WORD_W    = 16,
  parameter  int unsigned ROWS      = 4,
  parameter  int unsigned COLS      = 4,
  parameter  int unsigned ELMS      = 2,
  localparam int unsigned ROW_WORDS = COLS * ELMS,
  localparam int unsigned EL_AW     = (ELMS > 1) ? $clog2(ELMS) : 1,
  localparam int unsigned COL_AW    = (COLS > 1) ? $clog2(COLS) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  logic                               write_en_i,
  input  wbuf_pkg::slot_t                    write_addr_i,
  input  logic [ROW_WORDS-1:0][WORD_W-1:0]   wdata_i,
  input  logic                               read_en_i,
  input  logic [EL_AW-1:0]                   elms_read_addr_i,
  input  logic [COL_AW-1:0]                  cols_read_offs_i,
  output logic [ROWS-1:0][WORD_W-1:0]        rdata_o
);

  localparam int unsigned WA = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;

  logic [ROWS-1:0][ROW_WORDS-1:0][WORD_W-1:0] mem_q;
  logic [ROWS-1:0][WORD_W-1:0]                rdata_q;
  logic [WA-1:0]                              rd_word;

  // Word inside a row, elements of one column sit next to each other
  assign rd_word = WA'(cols_read_offs_i * ELMS + elms_read_addr_i);

  always_ff @(posedge clk_i) begin : row_write
    if (write_en_i) begin
      mem_q[write_addr_i] <= wdata_i;
    end
  end

  // All rows read the same word index in one shot
  always_ff @(posedge clk_i or negedge rst_ni) begin : element_read
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (clear_i) begin
      rdata_q <= '0;
    end else if (read_en_i) begin
      for (int r = 0; r < ROWS; r++) begin
        rdata_q[r] <= mem_q[r][rd_word];
      end
    end
  end

  assign rdata_o = rdata_q;

  // The row counter in the core must never point past the array
  a_write_addr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    write_en_i |-> (write_addr_i < ROWS)
  );

endmodule

//--- rtl/wbuf_gid_cache.sv
// Tag cache of resident quantization groups with usage-based slot reuse
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_gid_cache (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               lookup_i,   // Dequant load
  input  wbuf_pkg::gid_tag_t tag_i,
  input  logic               consume_i,  // One column consumed
  output logic               hit_o,
  output wbuf_pkg::slot_t    slot_o
);
  import wbuf_pkg::*;

  localparam int unsigned H  = `WBUF_HEIGHT;
  localparam int unsigned C  = `WBUF_C;
  localparam int unsigned UW = $clog2(C + 1);

  gid_tag_t [H-1:0]          tag_q;
  logic     [H-1:0]          valid_q;
  logic     [H-1:0][UW-1:0]  use_q;   // Columns still to be consumed per slot

  logic  hit;
  slot_t hit_slot;
  slot_t evict_slot;

  // Lowest valid slot holding the key
  always_comb begin : hit_detect
    hit      = 1'b0;
    hit_slot = '0;
    for (int h = H - 1; h >= 0; h--) begin
      if (valid_q[h] && tag_q[h] == tag_i) begin
        hit      = 1'b1;
        hit_slot = slot_t'(h);
      end
    end
  end

  // Invalid slots win over idle ones and slot 0 is the fallback
  always_comb begin : evict_select
    evict_slot = '0;
    for (int h = H - 1; h >= 0; h--) begin
      if (use_q[h] == '0) begin
        evict_slot = slot_t'(h);
      end
    end
    for (int h = H - 1; h >= 0; h--) begin
      if (!valid_q[h]) begin
        evict_slot = slot_t'(h);
      end
    end
  end

  assign hit_o  = lookup_i && hit;
  assign slot_o = hit ? hit_slot : evict_slot;

  always_ff @(posedge clk_i or negedge rst_ni) begin : slot_update
    if (!rst_ni) begin
      tag_q   <= '0;
      valid_q <= '0;
      use_q   <= '0;
    end else if (clear_i) begin
      tag_q   <= '0;
      valid_q <= '0;
      use_q   <= '0;
    end else begin
      for (int h = 0; h < H; h++) begin
        if (lookup_i && slot_o == slot_t'(h)) begin
          use_q[h] <= UW'(C);  // Group needed for a whole row again
          if (!hit) begin
            tag_q[h]   <= tag_i;
            valid_q[h] <= 1'b1;
          end
        end else if (consume_i && use_q[h] != '0) begin
          use_q[h] <= use_q[h] - 1'b1;
        end
      end
    end
  end

  // The slot picked by a lookup holds the key afterwards
  a_lookup_slot_holds_tag: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (lookup_i && !clear_i) |=>
      (valid_q[$past(slot_o)] && tag_q[$past(slot_o)] == $past(tag_i))
  );

endmodule

//--- rtl/wbuf_core.sv
// Weight buffer core with zero padding, load and read counters, storage and group cache
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_core (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  wbuf_ctrl_if.core                            ctrl,
  input  wbuf_pkg::elem_t  [`WBUF_D-1:0]       w_row_i,
  input  wbuf_pkg::qbyte_t [`WBUF_D-1:0]       qw_row_i,
  input  wbuf_pkg::qbyte_t [`WBUF_D-1:0]       zeros_row_i,
  input  logic [`WBUF_GID_W-1:0]               next_gidx_i,
  output wbuf_pkg::elem_t  [`WBUF_HEIGHT-1:0]  w_buffer_o,
  output wbuf_pkg::qbyte_t [`WBUF_HEIGHT-1:0]  qw_o,
  output wbuf_pkg::qbyte_t [`WBUF_HEIGHT-1:0]  zeros_o,
  output logic                                 gid_hit_o,
  output wbuf_pkg::slot_t                      gid_slot_o
);
  import wbuf_pkg::*;

  localparam int unsigned H      = `WBUF_HEIGHT;
  localparam int unsigned D      = `WBUF_D;
  localparam int unsigned C      = `WBUF_C;
  localparam int unsigned ELMS   = `WBUF_PIPE_REGS + 1;
  localparam int unsigned EL_AW  = (ELMS > 1) ? $clog2(ELMS) : 1;
  localparam int unsigned COL_AW = (C > 1) ? $clog2(C) : 1;

  slot_t             w_row_q;   // Next row to be written
  logic              row_on;
  elem_t  [D-1:0]    w_pad;
  qbyte_t [D-1:0]    qw_pad;
  qbyte_t [D-1:0]    zeros_pad;
  logic [EL_AW-1:0]  el_q;
  logic [COL_AW-1:0] col_q;
  logic              el_wrap;
  gid_tag_t          tag;

  assign row_on = dcnt_t'(w_row_q) < ctrl.height;

  // Rows past height and elements past width load as zero
  for (genvar d = 0; d < D; d++) begin : gen_pad
    logic keep;
    assign keep         = row_on && (dcnt_t'(d) < ctrl.width);
    assign w_pad[d]     = keep ? w_row_i[d] : '0;
    assign qw_pad[d]    = keep ? qw_row_i[d] : '0;
    assign zeros_pad[d] = keep ? zeros_row_i[d] : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : row_load_counter
    if (!rst_ni) begin
      w_row_q <= '0;
    end else if (clear_i) begin
      w_row_q <= '0;
    end else if (ctrl.load) begin
      w_row_q <= (w_row_q == slot_t'(H - 1)) ? '0 : w_row_q + 1'b1;
    end
  end

  assign el_wrap = (el_q == EL_AW'(ELMS - 1));

  // Element inside a column, then column inside the row
  always_ff @(posedge clk_i or negedge rst_ni) begin : read_counters
    if (!rst_ni) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (clear_i) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (ctrl.shift) begin
      if (el_wrap) begin
        el_q  <= '0;
        col_q <= (col_q == COL_AW'(C - 1)) ? '0 : col_q + 1'b1;
      end else begin
        el_q <= el_q + 1'b1;
      end
    end
  end

  wbuf_scm #(.WORD_W(`WBUF_ELEM_W), .ROWS(H), .COLS(C), .ELMS(ELMS)) i_w_scm (
    .clk_i, .rst_ni, .clear_i,
    .write_en_i       (ctrl.load),
    .write_addr_i     (w_row_q),
    .wdata_i          (w_pad),
    .read_en_i        (ctrl.shift),
    .elms_read_addr_i (el_q),
    .cols_read_offs_i (col_q),
    .rdata_o          (w_buffer_o)
  );

  wbuf_scm #(.WORD_W(8), .ROWS(H), .COLS(C), .ELMS(ELMS)) i_qw_scm (
    .clk_i, .rst_ni, .clear_i,
    .write_en_i       (ctrl.load),
    .write_addr_i     (w_row_q),
    .wdata_i          (qw_pad),
    .read_en_i        (ctrl.shift),
    .elms_read_addr_i (el_q),
    .cols_read_offs_i (col_q),
    .rdata_o          (qw_o)
  );

  wbuf_scm #(.WORD_W(8), .ROWS(H), .COLS(C), .ELMS(ELMS)) i_zeros_scm (
    .clk_i, .rst_ni, .clear_i,
    .write_en_i       (ctrl.load),
    .write_addr_i     (w_row_q),
    .wdata_i          (zeros_pad),
    .read_en_i        (ctrl.shift),
    .elms_read_addr_i (el_q),
    .cols_read_offs_i (col_q),
    .rdata_o          (zeros_o)
  );

  assign tag = {ctrl.stride_cnt, next_gidx_i};

  wbuf_gid_cache i_gid_cache (
    .clk_i, .rst_ni, .clear_i,
    .lookup_i  (ctrl.load && ctrl.dequant),
    .tag_i     (tag),
    .consume_i (ctrl.shift && el_wrap && ctrl.dequant),
    .hit_o     (gid_hit_o),
    .slot_o    (gid_slot_o)
  );

  // Programmed width comes from outside and must fit one row
  a_width_fits_row: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ctrl.load |-> (ctrl.width <= D)
  );

endmodule

//--- rtl/wbuf_top.sv
// Weight buffer top level with plain ports around the buffer core
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          clear_i,
  input  logic                                          load_i,
  input  logic                                          shift_i,
  input  logic                                          dequant_i,
  input  wbuf_pkg::dcnt_t                               width_i,
  input  wbuf_pkg::dcnt_t                               height_i,
  input  logic                                          stride_cnt_i,
  input  logic [`WBUF_GID_W-1:0]                        next_gidx_i,
  input  logic [`WBUF_DW-1:0]                           w_row_i,
  input  logic [`WBUF_D*8-1:0]                          qw_row_i,
  input  logic [`WBUF_D*8-1:0]                          zeros_row_i,
  output logic [`WBUF_HEIGHT-1:0][`WBUF_ELEM_W-1:0]     w_buffer_o,
  output logic [`WBUF_HEIGHT-1:0][7:0]                  qw_o,
  output logic [`WBUF_HEIGHT-1:0][7:0]                  zeros_o,
  output logic                                          gid_hit_o,
  output wbuf_pkg::slot_t                               gid_slot_o
);

  wbuf_ctrl_if ctrl ();

  // Strobes and settings go straight into the bundle
  assign ctrl.load       = load_i;
  assign ctrl.shift      = shift_i;
  assign ctrl.dequant    = dequant_i;
  assign ctrl.width      = width_i;
  assign ctrl.height     = height_i;
  assign ctrl.stride_cnt = stride_cnt_i;

  wbuf_core i_core (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .ctrl        (ctrl),
    .w_row_i     (w_row_i),
    .qw_row_i    (qw_row_i),
    .zeros_row_i (zeros_row_i),
    .next_gidx_i (next_gidx_i),
    .w_buffer_o  (w_buffer_o),
    .qw_o        (qw_o),
    .zeros_o     (zeros_o),
    .gid_hit_o   (gid_hit_o),
    .gid_slot_o  (gid_slot_o)
  );

endmodule

//--- sim/wbuf_checker.sv
// Scoreboard that models the weight buffer and its group cache and compares the DUT outputs
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_checker (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic                                      clear_i,
  input logic                                      load_i,
  input logic                                      shift_i,
  input logic                                      dequant_i,
  input wbuf_pkg::dcnt_t                           width_i,
  input wbuf_pkg::dcnt_t                           height_i,
  input logic                                      stride_cnt_i,
  input logic [`WBUF_GID_W-1:0]                    next_gidx_i,
  input logic [`WBUF_DW-1:0]                       w_row_i,
  input logic [`WBUF_D*8-1:0]                      qw_row_i,
  input logic [`WBUF_D*8-1:0]                      zeros_row_i,
  input logic [`WBUF_HEIGHT-1:0][`WBUF_ELEM_W-1:0] w_buffer_i,
  input logic [`WBUF_HEIGHT-1:0][7:0]              qw_i,
  input logic [`WBUF_HEIGHT-1:0][7:0]              zeros_i,
  input logic                                      gid_hit_i,
  input wbuf_pkg::slot_t                           gid_slot_i
);
  import wbuf_pkg::*;

  localparam int H  = `WBUF_HEIGHT;
  localparam int D  = `WBUF_D;
  localparam int C  = `WBUF_C;
  localparam int E  = `WBUF_PIPE_REGS + 1;  // Elements per column
  localparam int SW = $bits(slot_t);

  elem_t    w_mem   [H][D];
  qbyte_t   qw_mem  [H][D];
  qbyte_t   z_mem   [H][D];
  elem_t    exp_w   [H];
  qbyte_t   exp_qw  [H];
  qbyte_t   exp_z   [H];
  gid_tag_t tags    [H];
  logic     valid   [H];
  int       use_cnt [H];
  int       row_cnt;
  int       rd_idx;             // Element the next shift returns
  logic     pending;            // Outputs changed at the last edge
  int       n_compared = 0;
  int       test_errs  = 0;
  int       pass_tests = 0;
  int       fail_tests = 0;

  // Only elements inside the programmed width and height are stored
  function automatic logic keep_element(input int d);
    return (row_cnt < int'(height_i)) && (d < int'(width_i));
  endfunction

  // A hit takes the lowest matching slot and a miss takes the lowest invalid or idle slot
  function automatic logic [SW:0] expected_gid(input gid_tag_t tag);
    logic  hit;
    logic  found;
    slot_t slot;
    hit   = 1'b0;
    found = 1'b0;
    slot  = '0;
    for (int h = 0; h < H; h++) begin
      if (!hit && valid[h] && tags[h] == tag) begin
        hit  = 1'b1;
        slot = slot_t'(h);
      end
    end
    for (int h = 0; h < H; h++) begin
      if (!hit && !found && !valid[h]) begin
        found = 1'b1;
        slot  = slot_t'(h);
      end
    end
    for (int h = 0; h < H; h++) begin
      if (!hit && !found && use_cnt[h] == 0) begin
        found = 1'b1;
        slot  = slot_t'(h);
      end
    end
    return {hit, slot};
  endfunction

  task automatic compare_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0d ns %s expected 0x%h got 0x%h", $time, name, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("test %s passed", name);
      pass_tests++;
    end else begin
      $display("test %s failed with %0d mismatches", name, test_errs);
      fail_tests++;
    end
    test_errs = 0;
  endtask

  task automatic print_totals();
    $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
  endtask

  // Model state moves at the same edge as the DUT registers
  always @(posedge clk_i or negedge rst_ni) begin : model_update
    logic [SW:0] gid;
    logic        lookup;
    logic        consume;
    if (!rst_ni || clear_i) begin
      row_cnt = 0;
      rd_idx  = 0;
      pending = 1'b1;
      for (int h = 0; h < H; h++) begin
        exp_w[h]   = '0;
        exp_qw[h]  = '0;
        exp_z[h]   = '0;
        tags[h]    = '0;
        valid[h]   = 1'b0;
        use_cnt[h] = 0;
      end
    end else begin
      lookup  = load_i && dequant_i;
      consume = shift_i && dequant_i && (rd_idx % E == E - 1);
      gid     = expected_gid({stride_cnt_i, next_gidx_i});
      pending = shift_i;
      if (shift_i) begin  // Read sees the rows from before this edge's write
        for (int h = 0; h < H; h++) begin
          exp_w[h]  = w_mem[h][rd_idx];
          exp_qw[h] = qw_mem[h][rd_idx];
          exp_z[h]  = z_mem[h][rd_idx];
        end
        rd_idx = (rd_idx + 1) % D;
      end
      for (int h = 0; h < H; h++) begin
        if (lookup && gid[SW-1:0] == slot_t'(h)) begin
          use_cnt[h] = C;
          if (!gid[SW]) begin
            tags[h]  = {stride_cnt_i, next_gidx_i};
            valid[h] = 1'b1;
          end
        end else if (consume && use_cnt[h] != 0) begin
          use_cnt[h]--;
        end
      end
      if (load_i) begin
        for (int d = 0; d < D; d++) begin
          w_mem[row_cnt][d]  = keep_element(d) ? w_row_i[d*`WBUF_ELEM_W +: `WBUF_ELEM_W] : '0;
          qw_mem[row_cnt][d] = keep_element(d) ? qw_row_i[d*8 +: 8] : '0;
          z_mem[row_cnt][d]  = keep_element(d) ? zeros_row_i[d*8 +: 8] : '0;
        end
        row_cnt = (row_cnt + 1) % H;
      end
    end
  end

  // Registered and combinational outputs are settled at the falling edge
  always @(negedge clk_i) begin : compare_outputs
    logic [SW:0] gid;
    if (rst_ni) begin
      gid = expected_gid({stride_cnt_i, next_gidx_i});
      compare_value("gid_hit_o", 16'(load_i && dequant_i && gid[SW]), 16'(gid_hit_i));
      if (load_i && dequant_i) begin
        compare_value("gid_slot_o", 16'(gid[SW-1:0]), 16'(gid_slot_i));
      end
      if (pending) begin
        for (int h = 0; h < H; h++) begin
          compare_value($sformatf("w_buffer_o[%0d]", h), exp_w[h], w_buffer_i[h]);
          compare_value($sformatf("qw_o[%0d]", h), 16'(exp_qw[h]), 16'(qw_i[h]));
          compare_value($sformatf("zeros_o[%0d]", h), 16'(exp_z[h]), 16'(zeros_i[h]));
        end
        n_compared++;
      end
    end
  end

endmodule

//--- sim/tb_wbuf_top.sv
// Testbench for the weight buffer with random rows, element streaming and group cache traffic
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module tb_wbuf_top;
  import wbuf_pkg::*;

  localparam int H = `WBUF_HEIGHT;
  localparam int D = `WBUF_D;

  logic                                      clk_i = 1'b0;
  logic                                      rst_ni;
  logic                                      clear_i;
  logic                                      load_i;
  logic                                      shift_i;
  logic                                      dequant_i;
  dcnt_t                                     width_i;
  dcnt_t                                     height_i;
  logic                                      stride_cnt_i;
  logic [`WBUF_GID_W-1:0]                    next_gidx_i;
  logic [`WBUF_DW-1:0]                       w_row_i;
  logic [`WBUF_D*8-1:0]                      qw_row_i;
  logic [`WBUF_D*8-1:0]                      zeros_row_i;
  logic [`WBUF_HEIGHT-1:0][`WBUF_ELEM_W-1:0] w_buffer_o;
  logic [`WBUF_HEIGHT-1:0][7:0]              qw_o;
  logic [`WBUF_HEIGHT-1:0][7:0]              zeros_o;
  logic                                      gid_hit_o;
  slot_t                                     gid_slot_o;
  logic [31:0]                               lcg_state;
  logic                                      timed_out;

  always #20 clk_i = ~clk_i;  // 40 ns period

  wbuf_top wbuf_top_inst (.*);

  wbuf_checker chk (
    .*,
    .w_buffer_i (w_buffer_o),
    .qw_i       (qw_o),
    .zeros_i    (zeros_o),
    .gid_hit_i  (gid_hit_o),
    .gid_slot_i (gid_slot_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_random(output logic [31:0] value);
    lcg_state = lcg_next(lcg_state);
    value     = lcg_state;
  endtask

  task automatic wait_compare(input int target);
    int waited;
    waited = 0;
    while (chk.n_compared < target && waited < 8) begin
      @(posedge clk_i);
      waited++;
    end
    if (chk.n_compared < target) begin
      chk.report_error("Timeout: no output comparison within 8 cycles of a shift or clear");
      timed_out = 1'b1;
    end
  endtask

  // One cycle of strobes, taken by the DUT at the next rising edge
  task automatic pulse_strobes(input logic ld, input logic sh, input logic cl, input logic dq);
    int target;
    target    = chk.n_compared + 1;
    load_i    <= ld;
    shift_i   <= sh;
    clear_i   <= cl;
    dequant_i <= dq;
    @(posedge clk_i);
    load_i    <= 1'b0;
    shift_i   <= 1'b0;
    clear_i   <= 1'b0;
    dequant_i <= 1'b0;
    if (sh || cl) begin
      wait_compare(target);
    end
  endtask

  task automatic load_random_row(input logic dq);
    logic [31:0] r;
    for (int i = 0; i < `WBUF_DW / 32; i++) begin
      draw_random(r);
      w_row_i[i*32 +: 32] <= r;
    end
    for (int i = 0; i < D / 4; i++) begin
      draw_random(r);
      qw_row_i[i*32 +: 32] <= r;
      draw_random(r);
      zeros_row_i[i*32 +: 32] <= r;
    end
    draw_random(r);
    next_gidx_i  <= `WBUF_GID_W'(r[25:24]);  // Few groups so that hits happen
    stride_cnt_i <= r[28];
    pulse_strobes(1'b1, 1'b0, 1'b0, dq);
  endtask

  initial begin : stimulus
    logic [31:0] r;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    load_i       = 1'b0;
    shift_i      = 1'b0;
    dequant_i    = 1'b0;
    width_i      = dcnt_t'(D);
    height_i     = dcnt_t'(H);
    stride_cnt_i = 1'b0;
    next_gidx_i  = '0;
    w_row_i      = '0;
    qw_row_i     = '0;
    zeros_row_i  = '0;
    lcg_state    = 32'd30;
    timed_out    = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait_compare(1);
    chk.finish_test("outputs after reset");

    for (int h = 0; h < H; h++) load_random_row(1'b0);
    for (int n = 0; n < 2 * D; n++) pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
    chk.finish_test("full rows streamed twice");

    width_i  <= dcnt_t'(D - 3);
    height_i <= dcnt_t'(H - 2);
    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);  // Back to row 0 and element 0
    for (int h = 0; h < H; h++) load_random_row(1'b0);
    for (int n = 0; n < D; n++) pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
    chk.finish_test("width and height padding");

    width_i  <= dcnt_t'(D);
    height_i <= dcnt_t'(H);
    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    for (int h = 0; h < H; h++) load_random_row(1'b0);
    for (int n = 0; n < D; n++) pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
    chk.finish_test("quantized and zero point streams");

    for (int n = 0; n < 3; n++) pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    for (int n = 0; n < 3; n++) pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
    chk.finish_test("clear in mid stream");

    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    for (int i = 0; i < 24; i++) begin
      load_random_row(1'b1);
      draw_random(r);
      for (int s = 0; s < int'(r[30:29]); s++) pulse_strobes(1'b0, 1'b1, 1'b0, 1'b1);
    end
    chk.finish_test("group cache hits and eviction");

    chk.print_totals();
    if (chk.fail_tests == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- wbuf_top.f
+incdir+rtl
rtl/wbuf_pkg.sv
rtl/wbuf_ctrl_if.sv
rtl/wbuf_scm.sv
rtl/wbuf_gid_cache.sv
rtl/wbuf_core.sv
rtl/wbuf_top.sv
sim/wbuf_checker.sv
sim/tb_wbuf_top.sv

//--- run.sh
#!/bin/sh
# Build the weight buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_wbuf_top -f wbuf_top.f -o sim_wbuf
./obj_dir/sim_wbuf | tee sim.log
if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
